// File: source/ppu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Screen sizes, CPU register selects, OAM record layout and the RGB palette
// Sprite count is fixed here and sets the OAM size (4 bytes per slot)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ppu_pkg;

    // Raster geometry, NTSC-style
    localparam logic [8:0] SCREEN_WIDTH          = 9'd341;  // Dots per line
    localparam logic [8:0] SCREEN_HEIGHT         = 9'd262;  // Lines per frame
    localparam logic [8:0] SCREEN_VISIBLE_WIDTH  = 9'd256;
    localparam logic [8:0] SCREEN_VISIBLE_HEIGHT = 9'd240;
    localparam logic [8:0] VBLANK_LINE           = 9'd241;  // First line of vblank

    // CPU register selects
    localparam logic [2:0] RS_PPUCTRL   = 3'd0;
    localparam logic [2:0] RS_PPUMASK   = 3'd1;
    localparam logic [2:0] RS_PPUSTATUS = 3'd2;
    localparam logic [2:0] RS_OAMADDR   = 3'd3;
    localparam logic [2:0] RS_OAMDATA   = 3'd4;

    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    // Sprite slots
    localparam int NUM_SPRITES      = 8;
    localparam int SLOT_INDEX_WIDTH = $clog2(NUM_SPRITES);
    localparam int SPRITE_SIZE      = 8;   // Box edge in dots

    // Byte order inside one 4-byte OAM record
    localparam logic [1:0] OAM_BYTE_Y      = 2'd0;
    localparam logic [1:0] OAM_BYTE_COLOUR = 2'd1;
    localparam logic [1:0] OAM_BYTE_X      = 2'd2;
    localparam logic [1:0] OAM_BYTE_FLAGS  = 2'd3;  // Bit 0 enables the slot

    // Bit positions in PPUMASK and PPUCTRL
    localparam int MASK_GREYSCALE    = 0;
    localparam int MASK_SHOW_SPRITES = 4;
    localparam int CTRL_NMI_ENABLE   = 7;

    // 64-entry master palette, 24-bit RGB
    localparam logic [23:0] PALETTE [0:63] = '{
        24'h7C7C7C, 24'h0000FC, 24'h0000BC, 24'h4428BC,
        24'h940084, 24'hA80020, 24'hA81000, 24'h881400,
        24'h503000, 24'h007800, 24'h006800, 24'h005800,
        24'h004058, 24'h000000, 24'h000000, 24'h000000,
        24'hBCBCBC, 24'h0078F8, 24'h0058F8, 24'h6844FC,
        24'hD800CC, 24'hE40058, 24'hF83800, 24'hE45C10,
        24'hAC7C00, 24'h00B800, 24'h00A800, 24'h00A844,
        24'h008888, 24'h000000, 24'h000000, 24'h000000,
        24'hF8F8F8, 24'h3CBCFC, 24'h6888FC, 24'h9878F8,
        24'hF878F8, 24'hF85898, 24'hF87858, 24'hFCA044,
        24'hF8B800, 24'hB8F818, 24'h58D854, 24'h58F898,
        24'h00E8D8, 24'h787878, 24'h000000, 24'h000000,
        24'hFCFCFC, 24'hA4E4FC, 24'hB8B8F8, 24'hD8B8F8,
        24'hF8B8F8, 24'hF8A4C0, 24'hF0D0B0, 24'hFCE0A8,
        24'hF8D878, 24'hD8F878, 24'hB8F8B8, 24'hB8F8D8,
        24'h00FCFC, 24'hF8D8F8, 24'h000000, 24'h000000
    };

endpackage

// File: source/ppu_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU port has no handshake: writes land on the clock edge, reads are combinational
// Only PPUSTATUS reads back; OAM addresses of 32 and above are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ppu_regs (
    input  logic                             i_clk,
    input  logic                             i_reset_n,
    input  logic                             i_cs_n,          // Chip select
    input  logic                             i_rw,            // Read / ~write
    input  logic [2:0]                       i_rs,            // Register select
    input  logic [7:0]                       i_data,
    input  logic                             i_vblank_start,
    input  logic                             i_vblank_end,
    input  logic                             i_sprite0_hit,
    output logic [7:0]                       o_data,
    output logic                             o_int_n,         // To CPU ~NMI
    output logic [7:0]                       o_ppuctrl,
    output logic [7:0]                       o_ppumask,
    output logic [ppu_pkg::NUM_SPRITES-1:0]  o_slot_we,       // One-hot slot strobe
    output logic [1:0]                       o_oam_byte,
    output logic [7:0]                       o_oam_wdata
);
    import ppu_pkg::*;

    logic [7:0] r_ppuctrl;
    logic [7:0] r_ppumask;
    logic [7:0] r_oam_addr;
    logic       r_vblank;       // Becomes status bit 7
    logic       r_sprite0;      // Status bit 6
    logic       w_write;
    logic       w_status_read;
    logic       w_oam_write;

    assign w_write       = !i_cs_n && (i_rw == RW_WRITE);
    assign w_status_read = !i_cs_n && (i_rw == RW_READ) && (i_rs == RS_PPUSTATUS);
    assign w_oam_write   = w_write && (i_rs == RS_OAMDATA);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_ppuctrl  <= '0;
            r_ppumask  <= '0;
            r_oam_addr <= '0;
        end
        else if (w_write)
        begin
            case (i_rs)
                RS_PPUCTRL: r_ppuctrl  <= i_data;
                RS_PPUMASK: r_ppumask  <= i_data;
                RS_OAMADDR: r_oam_addr <= i_data;
                RS_OAMDATA: r_oam_addr <= r_oam_addr + 8'd1;  // Step after each data byte
                default:    ;
            endcase
        end
    end

    // Vblank and sprite-zero flags
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_vblank  <= 1'b0;
            r_sprite0 <= 1'b0;
        end
        else
        begin
            if (i_vblank_start)
                r_vblank <= 1'b1;                           // Start wins over a read
            else if (i_vblank_end || w_status_read)
                r_vblank <= 1'b0;
            if (i_sprite0_hit)
                r_sprite0 <= 1'b1;
            else if (i_vblank_end)
                r_sprite0 <= 1'b0;                          // Held until the frame restarts
        end
    end

    always_comb
    begin
        o_data = '0;
        if (w_status_read)
            o_data = {r_vblank, r_sprite0, 6'b000000};
    end

    // OAM write decode, slot from address bits 4:2
    always_comb
    begin
        o_slot_we = '0;
        if (w_oam_write && (r_oam_addr < 8'(NUM_SPRITES * 4)))
            o_slot_we[r_oam_addr[2 +: SLOT_INDEX_WIDTH]] = 1'b1;
    end

    assign o_oam_byte  = r_oam_addr[1:0];
    assign o_oam_wdata = i_data;

    assign o_int_n   = !(r_vblank && r_ppuctrl[CTRL_NMI_ENABLE]);
    assign o_ppuctrl = r_ppuctrl;
    assign o_ppumask = r_ppumask;

endmodule

// File: source/ppu_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running raster, never stalls; reset parks it on the last dot of the frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ppu_timing (
    input  logic       i_clk,
    input  logic       i_reset_n,
    output logic [8:0] o_dot_x,
    output logic [8:0] o_dot_y,
    output logic       o_visible,
    output logic       o_vblank_start,    // High for dot (0, 241)
    output logic       o_vblank_end       // High for dot (340, 261)
);
    import ppu_pkg::*;

    logic [8:0] r_dot_x;
    logic [8:0] r_dot_y;
    logic       w_last_dot;
    logic       w_last_line;

    assign w_last_dot  = (r_dot_x == SCREEN_WIDTH - 9'd1);
    assign w_last_line = (r_dot_y == SCREEN_HEIGHT - 9'd1);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_dot_x <= SCREEN_WIDTH - 9'd1;     // First counted dot is (0,0)
            r_dot_y <= SCREEN_HEIGHT - 9'd1;
        end
        else if (w_last_dot)
        begin
            r_dot_x <= '0;
            r_dot_y <= w_last_line ? 9'd0 : r_dot_y + 9'd1;
        end
        else
        begin
            r_dot_x <= r_dot_x + 9'd1;
        end
    end

    assign o_dot_x   = r_dot_x;
    assign o_dot_y   = r_dot_y;
    assign o_visible = (r_dot_x < SCREEN_VISIBLE_WIDTH) && (r_dot_y < SCREEN_VISIBLE_HEIGHT);

    // Each raster position lasts one cycle, so these are single-cycle pulses
    assign o_vblank_start = (r_dot_x == 9'd0) && (r_dot_y == VBLANK_LINE);
    assign o_vblank_end   = w_last_dot && w_last_line;

endmodule

// File: source/ppu_sprite_slot.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Solid box only, no pattern data; hit is combinational on the current dot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ppu_sprite_slot (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_we,         // This slot's OAM strobe
    input  logic [1:0] i_byte,       // Byte within the record
    input  logic [7:0] i_wdata,
    input  logic [8:0] i_dot_x,
    input  logic [8:0] i_dot_y,
    output logic       o_hit,
    output logic [7:0] o_colour
);
    import ppu_pkg::*;

    logic [7:0] r_y;
    logic [7:0] r_colour;
    logic [7:0] r_x;
    logic       r_enable;
    logic       w_in_x;
    logic       w_in_y;

    // Attribute bytes
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            case (i_byte)
                OAM_BYTE_Y:      r_y      <= i_wdata;
                OAM_BYTE_COLOUR: r_colour <= i_wdata;
                OAM_BYTE_X:      r_x      <= i_wdata;
                default:         ;                      // Flags handled below
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_enable <= 1'b0;
        else if (i_we && (i_byte == OAM_BYTE_FLAGS))
            r_enable <= i_wdata[0];
    end

    // Box covers X..X+7 and Y..Y+7, 9-bit compare so X=255 cannot wrap
    assign w_in_x = (i_dot_x >= {1'b0, r_x}) && (i_dot_x < {1'b0, r_x} + 9'(SPRITE_SIZE));
    assign w_in_y = (i_dot_y >= {1'b0, r_y}) && (i_dot_y < {1'b0, r_y} + 9'(SPRITE_SIZE));

    assign o_hit    = r_enable && w_in_x && w_in_y;
    assign o_colour = r_colour;

endmodule

// File: source/ppu_pixel_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lowest slot index wins; video outputs are one cycle behind the raster timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ppu_pixel_mux (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic [7:0]                         i_ppumask,
    input  logic [8:0]                         i_dot_x,
    input  logic [8:0]                         i_dot_y,
    input  logic                               i_visible,
    input  logic [ppu_pkg::NUM_SPRITES-1:0]    i_hit,
    input  logic [ppu_pkg::NUM_SPRITES*8-1:0]  i_colour,     // Slot n at bits 8n+7:8n
    output logic [7:0]                         o_video_red,
    output logic [7:0]                         o_video_green,
    output logic [7:0]                         o_video_blue,
    output logic [8:0]                         o_video_x,
    output logic [8:0]                         o_video_y,
    output logic                               o_video_visible,
    output logic                               o_sprite0_hit   // Pulse, slot 0 drawn
);
    import ppu_pkg::*;

    logic [SLOT_INDEX_WIDTH-1:0] w_index;
    logic                        w_any_hit;
    logic                        w_show;
    logic [5:0]                  w_colour_index;
    logic [23:0]                 w_rgb;

    // Priority pick, scan downward so the lowest hitting index is kept last
    always_comb
    begin
        w_index   = '0;
        w_any_hit = 1'b0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--)
        begin
            if (i_hit[i])
            begin
                w_index   = SLOT_INDEX_WIDTH'(i);
                w_any_hit = 1'b1;
            end
        end
    end

    assign w_show = w_any_hit && i_visible && i_ppumask[MASK_SHOW_SPRITES];

    always_comb
    begin
        w_colour_index = i_colour[w_index * 8 +: 6];
        if (i_ppumask[MASK_GREYSCALE])
            w_colour_index = w_colour_index & 6'h30;   // Grey column of the palette
    end

    assign w_rgb = PALETTE[w_colour_index];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_video_red     <= '0;
            o_video_green   <= '0;
            o_video_blue    <= '0;
            o_video_visible <= 1'b0;
            o_sprite0_hit   <= 1'b0;
        end
        else
        begin
            o_video_red     <= w_show ? w_rgb[23:16] : 8'd0;  // Black when nothing shown
            o_video_green   <= w_show ? w_rgb[15:8]  : 8'd0;
            o_video_blue    <= w_show ? w_rgb[7:0]   : 8'd0;
            o_video_visible <= i_visible;
            o_sprite0_hit   <= w_show && i_hit[0];            // Slot 0 always wins its own hit
        end
    end

    // Coordinates travel with the colour
    always_ff @(posedge i_clk)
    begin
        o_video_x <= i_dot_x;
        o_video_y <= i_dot_y;
    end

endmodule

// File: source/ppu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprites only: no video memory bus, no background, no OAM read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ppu (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_cs_n,
    input  logic       i_rw,
    input  logic [2:0] i_rs,
    input  logic [7:0] i_data,
    output logic [7:0] o_data,
    output logic       o_int_n,
    output logic [7:0] o_video_red,
    output logic [7:0] o_video_green,
    output logic [7:0] o_video_blue,
    output logic [8:0] o_video_x,
    output logic [8:0] o_video_y,
    output logic       o_video_visible,
    output logic [7:0] o_debug_ppuctrl,
    output logic [7:0] o_debug_ppumask
);
    import ppu_pkg::*;

    logic [7:0]               w_ppumask;
    logic [NUM_SPRITES-1:0]   w_slot_we;
    logic [1:0]               w_oam_byte;
    logic [7:0]               w_oam_wdata;
    logic [8:0]               w_dot_x;
    logic [8:0]               w_dot_y;
    logic                     w_visible;
    logic                     w_vblank_start;
    logic                     w_vblank_end;
    logic                     w_sprite0_hit;
    logic [NUM_SPRITES-1:0]   w_hit;
    logic [NUM_SPRITES*8-1:0] w_colour;

    ppu_regs u_regs (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_cs_n         (i_cs_n),
        .i_rw           (i_rw),
        .i_rs           (i_rs),
        .i_data         (i_data),
        .i_vblank_start (w_vblank_start),
        .i_vblank_end   (w_vblank_end),
        .i_sprite0_hit  (w_sprite0_hit),
        .o_data         (o_data),
        .o_int_n        (o_int_n),
        .o_ppuctrl      (o_debug_ppuctrl),
        .o_ppumask      (w_ppumask),
        .o_slot_we      (w_slot_we),
        .o_oam_byte     (w_oam_byte),
        .o_oam_wdata    (w_oam_wdata)
    );

    ppu_timing u_timing (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .o_dot_x        (w_dot_x),
        .o_dot_y        (w_dot_y),
        .o_visible      (w_visible),
        .o_vblank_start (w_vblank_start),
        .o_vblank_end   (w_vblank_end)
    );

    // One slot per OAM record
    for (genvar g = 0; g < NUM_SPRITES; g++)
    begin : g_slot
        ppu_sprite_slot u_slot (
            .i_clk     (i_clk),
            .i_reset_n (i_reset_n),
            .i_we      (w_slot_we[g]),
            .i_byte    (w_oam_byte),
            .i_wdata   (w_oam_wdata),
            .i_dot_x   (w_dot_x),
            .i_dot_y   (w_dot_y),
            .o_hit     (w_hit[g]),
            .o_colour  (w_colour[g * 8 +: 8])
        );
    end

    ppu_pixel_mux u_pixel_mux (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_ppumask       (w_ppumask),
        .i_dot_x         (w_dot_x),
        .i_dot_y         (w_dot_y),
        .i_visible       (w_visible),
        .i_hit           (w_hit),
        .i_colour        (w_colour),
        .o_video_red     (o_video_red),
        .o_video_green   (o_video_green),
        .o_video_blue    (o_video_blue),
        .o_video_x       (o_video_x),
        .o_video_y       (o_video_y),
        .o_video_visible (o_video_visible),
        .o_sprite0_hit   (w_sprite0_hit)
    );

    assign o_debug_ppumask = w_ppumask;

endmodule

// File: tb/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8 ns clock, reset low for the first 4 rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_reset_n
);
    localparam time HALF_PERIOD = 4ns;

    initial
    begin
        o_clk     = 1'b0;
        o_reset_n = 1'b0;
        repeat (4) @(negedge o_clk);   // Rising edges at 4, 12, 20 and 28 ns see reset
        o_reset_n <= 1'b1;             // Released on a falling edge like every DUT input
    end

    always #HALF_PERIOD o_clk = ~o_clk;

endmodule

// File: tb/tb_ppu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs tb/ppu_stimulus.txt from the project root; a pixel wait gives up after two frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ppu;
    import ppu_pkg::*;

    localparam int PIXEL_TIMEOUT = 2 * 341 * 262;   // Two full frames of dots

    logic       clk;
    logic       reset_n;
    logic       cs_n;
    logic       rw;
    logic [2:0] rs;
    logic [7:0] data_in;
    logic [7:0] data_out;
    logic       int_n;
    logic [7:0] video_red;
    logic [7:0] video_green;
    logic [7:0] video_blue;
    logic [8:0] video_x;
    logic [8:0] video_y;
    logic       video_visible;
    logic [7:0] debug_ppuctrl;
    logic [7:0] debug_ppumask;
    int         error_count;
    int         check_count;

    tb_clock u_clock (.o_clk(clk), .o_reset_n(reset_n));

    ppu u_dut (
        .i_clk (clk), .i_reset_n (reset_n), .i_cs_n (cs_n), .i_rw (rw),
        .i_rs (rs), .i_data (data_in), .o_data (data_out), .o_int_n (int_n),
        .o_video_red (video_red), .o_video_green (video_green),
        .o_video_blue (video_blue), .o_video_x (video_x), .o_video_y (video_y),
        .o_video_visible (video_visible),
        .o_debug_ppuctrl (debug_ppuctrl), .o_debug_ppumask (debug_ppumask)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Visible area is the top-left 256 by 240 dots
    function automatic logic in_visible_area(input int x, input int y);
        return (x < SCREEN_VISIBLE_WIDTH) && (y < SCREEN_VISIBLE_HEIGHT);
    endfunction

    // Tasks below start and end on a falling edge
    task automatic write_reg(input logic [2:0] sel, input logic [7:0] value);
        cs_n    = 1'b0;
        rw      = RW_WRITE;
        rs      = sel;
        data_in = value;
        @(negedge clk);                    // Write lands on the rising edge in between
        cs_n = 1'b1;
        if (sel == RS_PPUCTRL)
            check_value(debug_ppuctrl, value, "PPUCTRL on debug port");
        if (sel == RS_PPUMASK)
            check_value(debug_ppumask, value, "PPUMASK on debug port");
        @(negedge clk);                    // One idle cycle between commands
    endtask

    task automatic read_reg(input logic [2:0] sel, input logic [7:0] expected);
        cs_n = 1'b0;
        rw   = RW_READ;
        rs   = sel;
        #2;                                // Read data is combinational, settled well before the edge
        check_value(data_out, expected, $sformatf("read of register %0d", sel));
        @(negedge clk);
        cs_n = 1'b1;
        if (sel == RS_PPUSTATUS)
            check_value(int_n, 1'b1, "o_int_n after status read");   // Vblank flag cleared
        @(negedge clk);
    endtask

    task automatic wait_video_pos(input logic [8:0] x, input logic [8:0] y, output bit found);
        int cycles;
        cycles = 0;
        @(negedge clk);                    // Skip a pixel registered before the last write
        while (!(video_x == x && video_y == y) && cycles < PIXEL_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        found = (video_x == x) && (video_y == y);
        if (!found)
        begin
            $display("Timeout: video position (%0d,%0d) not reached within two frames", x, y);
            error_count++;
        end
    endtask

    task automatic run_stimulus();
        int               fd;
        int               code;
        int               a;
        int               b;
        logic [7:0]       cmd;
        logic [7:0]       d0;
        logic [7:0]       d1;
        logic [7:0]       d2;
        logic [8*128-1:0] line_buf;
        bit               found;
        bit               stop;
        fd = $fopen("tb/ppu_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file tb/ppu_stimulus.txt");
            error_count++;
            return;
        end
        stop = 1'b0;
        while (!stop)
        begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1)
                break;                                              // End of file
            found = 1'b1;
            case (cmd)
                "#": code = $fgets(line_buf, fd);                   // Comment line
                "W":
                begin
                    code = $fscanf(fd, "%d %h", a, d0);
                    stop = (code != 2);
                    if (!stop)
                        write_reg(a[2:0], d0);
                end
                "R":
                begin
                    code = $fscanf(fd, "%d %h", a, d0);
                    stop = (code != 2);
                    if (!stop)
                        read_reg(a[2:0], d0);
                end
                "P":
                begin
                    code = $fscanf(fd, "%d %d %h %h %h", a, b, d0, d1, d2);
                    stop = (code != 5);
                    if (!stop)
                    begin
                        wait_video_pos(a[8:0], b[8:0], found);
                        stop = !found;
                        if (found)
                        begin
                            check_value(video_red, d0, $sformatf("red at (%0d,%0d)", a, b));
                            check_value(video_green, d1, $sformatf("green at (%0d,%0d)", a, b));
                            check_value(video_blue, d2, $sformatf("blue at (%0d,%0d)", a, b));
                            check_value(video_visible, in_visible_area(a, b),
                                        $sformatf("visible at (%0d,%0d)", a, b));
                        end
                    end
                end
                "I":
                begin
                    code = $fscanf(fd, "%d", a);
                    stop = (code != 1);
                    if (!stop)
                    begin
                        wait_video_pos(9'd0, VBLANK_LINE, found);   // Flag set once this dot is out
                        stop = !found;
                        if (found)
                        begin
                            check_value(int_n, a[0], "o_int_n after vblank start");
                            check_value(video_visible, in_visible_area(0, VBLANK_LINE),
                                        "visible on the first vblank line");
                        end
                    end
                end
                default:
                begin
                    $display("Unknown command '%c' in the stimulus file", cmd);
                    error_count++;
                    stop = 1'b1;
                end
            endcase
            if (stop && cmd inside {"W", "R", "P", "I"} && found)
            begin
                $display("Malformed '%c' line in the stimulus file", cmd);
                error_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_for_reset(output bit released);
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        released = (reset_n === 1'b1);
    endtask

    initial
    begin
        bit released;
        cs_n        = 1'b1;
        rw          = RW_READ;
        rs          = 3'd0;
        data_in     = 8'd0;
        error_count = 0;
        check_count = 0;
        @(negedge clk);                    // One rising edge has seen reset by now
        check_value(int_n, 1'b1, "o_int_n during reset");
        check_value({video_red, video_green, video_blue}, 24'd0, "RGB during reset");
        check_value(debug_ppuctrl, 8'd0, "PPUCTRL during reset");
        check_value(debug_ppumask, 8'd0, "PPUMASK during reset");
        wait_for_reset(released);
        if (!released)
        begin
            $display("Reset was never released by the clock generator");
            error_count++;
        end
        else
        begin
            run_stimulus();
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: tb/ppu_stimulus.txt
# Commands: W rs data | R rs expected | P x y red green blue | I expected_int_n
# rs, x, y and int_n in decimal; data and colours in hex
R 2 00
W 0 04
W 1 10
W 3 00
W 4 1E
W 4 16
W 4 14
W 4 01
W 4 22
W 4 2A
W 4 18
W 4 01
W 4 3C
W 4 30
W 4 3C
W 4 00
P 25 35 F8 38 00
P 30 40 58 D8 54
P 100 100 00 00 00
P 62 62 00 00 00
W 1 00
P 22 32 00 00 00
W 1 11
P 22 32 BC BC BC
P 30 40 F8 F8 F8
W 1 10
W 3 20
W 4 80
W 4 0F
P 25 35 F8 38 00
W 0 80
I 0
R 2 C0

// File: verilog.f
source/ppu_pkg.sv
source/ppu_regs.sv
source/ppu_timing.sv
source/ppu_sprite_slot.sv
source/ppu_pixel_mux.sv
source/ppu.sv
tb/tb_clock.sv
tb/tb_ppu.sv

// File: Bender.yml
package:
  name: ppu

sources:
  - files:
      - source/ppu_pkg.sv
      - source/ppu_regs.sv
      - source/ppu_timing.sv
      - source/ppu_sprite_slot.sv
      - source/ppu_pixel_mux.sv
      - source/ppu.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tb_ppu.sv
